/* hdl/xswitch_pkg.sv */
// Shared widths, constants and types for the lane crosspoint switch, imported by every RTL block
`default_nettype none

package xswitch_pkg;

    // Lane and stream geometry
    localparam int LANE_COUNT = 16;
    localparam int DATA_BYTES = 8;
    localparam int DATA_WIDTH = DATA_BYTES * 8;
    localparam int SEL_WIDTH  = $clog2(LANE_COUNT);

    // Stream or lane data word and its byte mask
    typedef logic [DATA_WIDTH-1:0] word_t;
    typedef logic [DATA_BYTES-1:0] keep_t;

    // Ethernet header fields
    typedef logic [47:0] mac_t;
    typedef logic [15:0] ethertype_t;

    // Lane index and the packed per-lane arrays, lane 0 in the low bits
    typedef logic [SEL_WIDTH-1:0] sel_t;
    typedef sel_t  [LANE_COUNT-1:0] sel_arr_t;
    typedef word_t [LANE_COUNT-1:0] lane_data_arr_t;
    typedef keep_t [LANE_COUNT-1:0] lane_ctl_arr_t;

    // Frames of this type carry a new routing table
    localparam ethertype_t CFG_ETHERTYPE = 16'h8099;

    // XGMII idle, every byte a control character
    localparam word_t IDLE_DATA = {DATA_BYTES{8'h07}};
    localparam keep_t IDLE_CTL  = '1;

endpackage

`default_nettype wire

/* hdl/eth_hdr_if.sv */
// Parsed Ethernet header with valid/ready handshake, driven by the parser and taken by a consumer
`timescale 1ns/100ps
`default_nettype none

interface eth_hdr_if import xswitch_pkg::*; ();

    logic       valid;
    logic       ready;
    mac_t       dest_mac;
    mac_t       src_mac;
    ethertype_t ethertype;

    // Fields are held until valid and ready meet on a clock edge
    modport source (
        output valid,
        output dest_mac,
        output src_mac,
        output ethertype,
        input  ready
    );

    modport sink (
        input  valid,
        input  dest_mac,
        input  src_mac,
        input  ethertype,
        output ready
    );

endinterface

`default_nettype wire

/* hdl/frame_stream_if.sv */
// 64-bit framed byte stream with keep mask and last, used between the parser and its consumer
`timescale 1ns/100ps
`default_nettype none

interface frame_stream_if import xswitch_pkg::*; ();

    word_t data;
    keep_t keep;
    logic  valid;
    logic  ready;
    logic  last;

    // Byte 0 sits in bits 7 to 0
    modport source (output data, output keep, output valid, output last, input ready);

    modport sink (input data, input keep, input valid, input last, output ready);

endinterface

`default_nettype wire

/* hdl/eth_hdr_parser.sv */
// Splits the 14-byte Ethernet header off a 64-bit frame stream and realigns the payload words
`timescale 1ns/100ps
`default_nettype none

module eth_hdr_parser import xswitch_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  word_t          in_data,
    input  keep_t          in_keep,
    input  logic           in_valid,
    input  logic           in_last,
    output logic           in_ready,
    eth_hdr_if.source      hdr,
    frame_stream_if.source payload,
    output logic           hdr_error
);

    typedef enum logic [1:0] {
        S_HDR0,
        S_HDR1,
        S_PAYLOAD
    } state_t;

    state_t     state;
    logic       hdr_valid_reg;
    logic       pl_valid_reg;
    logic       trail_pending;
    logic       hdr_error_reg;
    mac_t       dest_mac_reg;
    mac_t       src_mac_reg;
    ethertype_t type_reg;
    word_t      pl_data_reg;
    keep_t      pl_keep_reg;
    logic       pl_last_reg;
    // Bytes 6 and 7 of the previous input word
    logic [15:0] carry_data;
    logic [1:0]  carry_keep;
    logic        pl_free;
    logic        in_fire;
    logic        emit_tail;

    assign pl_free   = !pl_valid_reg || payload.ready;
    assign in_fire   = in_valid && in_ready;
    assign emit_tail = trail_pending && pl_free;

    // Stall while the header waits or the trailing word is still owed
    assign in_ready = !hdr_valid_reg && !trail_pending && ((state == S_HDR0) || pl_free);

    assign hdr.valid     = hdr_valid_reg;
    assign hdr.dest_mac  = dest_mac_reg;
    assign hdr.src_mac   = src_mac_reg;
    assign hdr.ethertype = type_reg;
    assign payload.valid = pl_valid_reg;
    assign payload.data  = pl_data_reg;
    assign payload.keep  = pl_keep_reg;
    assign payload.last  = pl_last_reg;
    assign hdr_error     = hdr_error_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= S_HDR0;
            hdr_valid_reg <= 1'b0;
            pl_valid_reg  <= 1'b0;
            trail_pending <= 1'b0;
            hdr_error_reg <= 1'b0;
        end else begin
            hdr_error_reg <= 1'b0;
            if (hdr_valid_reg && hdr.ready) begin
                hdr_valid_reg <= 1'b0;
            end
            if (pl_valid_reg && payload.ready) begin
                pl_valid_reg <= 1'b0;
            end
            if (in_fire) begin
                case (state)
                    S_HDR0: begin
                        if (in_last) begin
                            hdr_error_reg <= 1'b1;
                        end else begin
                            state <= S_HDR1;
                        end
                    end
                    S_HDR1: begin
                        // Byte 13 is byte 5 of the second word
                        if (in_last && !in_keep[5]) begin
                            hdr_error_reg <= 1'b1;
                            state         <= S_HDR0;
                        end else begin
                            hdr_valid_reg <= 1'b1;
                            if (in_last) begin
                                pl_valid_reg <= 1'b1;
                                state        <= S_HDR0;
                            end else begin
                                state <= S_PAYLOAD;
                            end
                        end
                    end
                    default: begin
                        pl_valid_reg <= 1'b1;
                        if (in_last && in_keep[6]) begin
                            trail_pending <= 1'b1;
                        end else if (in_last) begin
                            state <= S_HDR0;
                        end
                    end
                endcase
            end
            if (emit_tail) begin
                pl_valid_reg  <= 1'b1;
                trail_pending <= 1'b0;
                state         <= S_HDR0;
            end
        end
    end

    // Header fields and payload data
    always_ff @(posedge clk) begin
        if (in_fire && state == S_HDR0) begin
            for (int i = 0; i < 6; i++) begin
                dest_mac_reg[47 - 8*i -: 8] <= in_data[8*i +: 8];
            end
            src_mac_reg[47:32] <= {in_data[55:48], in_data[63:56]};
        end
        if (in_fire && state == S_HDR1) begin
            for (int i = 0; i < 4; i++) begin
                src_mac_reg[31 - 8*i -: 8] <= in_data[8*i +: 8];
            end
            type_reg   <= {in_data[39:32], in_data[47:40]};
            carry_data <= in_data[63:48];
            carry_keep <= in_keep[7:6];
            // Frame ending inside word 1 leaves at most two payload bytes
            pl_data_reg <= word_t'(in_data[63:48]);
            pl_keep_reg <= keep_t'(in_keep[7:6]);
            pl_last_reg <= 1'b1;
        end
        if (in_fire && state == S_PAYLOAD) begin
            pl_data_reg <= {in_data[47:0], carry_data};
            pl_keep_reg <= {in_keep[5:0], carry_keep};
            pl_last_reg <= in_last && !in_keep[6];
            carry_data  <= in_data[63:48];
            carry_keep  <= in_keep[7:6];
        end
        if (emit_tail) begin
            pl_data_reg <= word_t'(carry_data);
            pl_keep_reg <= keep_t'(carry_keep);
            pl_last_reg <= 1'b1;
        end
    end

    // Header held steady until the consumer takes it
    assert property (@(posedge clk) disable iff (rst)
        hdr.valid && !hdr.ready |=>
            hdr.valid && $stable({hdr.dest_mac, hdr.src_mac, hdr.ethertype}));

    // No input word is consumed while a header is pending
    assert property (@(posedge clk) disable iff (rst)
        hdr.valid && !hdr.ready |=> $stable(state) && !$rose(payload.valid));

endmodule

`default_nettype wire

/* hdl/xswitch_cfg.sv */
// Configuration engine, loads the sixteen lane selects from configuration frame payloads
`timescale 1ns/100ps
`default_nettype none

module xswitch_cfg import xswitch_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    eth_hdr_if.sink      hdr,
    frame_stream_if.sink payload,
    output sel_arr_t     select
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WORD0,
        S_WORD1,
        S_DRAIN
    } state_t;

    state_t state;
    logic   hdr_ready_reg;
    logic   pl_ready_reg;
    logic   hdr_fire;
    logic   pl_fire;

    assign hdr.ready     = hdr_ready_reg;
    assign payload.ready = pl_ready_reg;
    assign hdr_fire      = hdr.valid && hdr_ready_reg;
    assign pl_fire       = payload.valid && pl_ready_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= S_IDLE;
            hdr_ready_reg <= 1'b0;
            pl_ready_reg  <= 1'b0;
            // Identity routing
            for (int i = 0; i < LANE_COUNT; i++) begin
                select[i] <= sel_t'(i);
            end
        end else begin
            case (state)
                S_IDLE: begin
                    hdr_ready_reg <= 1'b1;
                    pl_ready_reg  <= 1'b0;
                    if (hdr_fire) begin
                        hdr_ready_reg <= 1'b0;
                        pl_ready_reg  <= 1'b1;
                        // Other frame types are swallowed whole
                        state <= (hdr.ethertype == CFG_ETHERTYPE) ? S_WORD0 : S_DRAIN;
                    end
                end
                default: begin
                    hdr_ready_reg <= 1'b0;
                    pl_ready_reg  <= 1'b1;
                    if (pl_fire && payload.last) begin
                        state         <= S_IDLE;
                        hdr_ready_reg <= 1'b1;
                        pl_ready_reg  <= 1'b0;
                    end else if (pl_fire && state == S_WORD0) begin
                        // Low nibble of byte k selects for lane k
                        for (int k = 0; k < DATA_BYTES; k++) begin
                            if (payload.keep[k]) begin
                                select[k] <= payload.data[8*k +: SEL_WIDTH];
                            end
                        end
                        state <= S_WORD1;
                    end else if (pl_fire && state == S_WORD1) begin
                        for (int k = 0; k < DATA_BYTES; k++) begin
                            if (payload.keep[k]) begin
                                select[DATA_BYTES + k] <= payload.data[8*k +: SEL_WIDTH];
                            end
                        end
                        state <= S_DRAIN;
                    end
                end
            endcase
        end
    end

    // Header and payload are never offered at once
    assert property (@(posedge clk) disable iff (rst) !(hdr.ready && payload.ready));

endmodule

`default_nettype wire

/* hdl/lane_crosspoint.sv */
// Registered sixteen-by-sixteen lane multiplexer, each output lane picks one input lane
`timescale 1ns/100ps
`default_nettype none

module lane_crosspoint import xswitch_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  sel_arr_t       select,
    input  lane_data_arr_t in_data,
    input  lane_ctl_arr_t  in_ctl,
    output lane_data_arr_t out_data,
    output lane_ctl_arr_t  out_ctl
);

    always_ff @(posedge clk) begin
        if (rst) begin
            // Lanes idle until routing starts
            for (int i = 0; i < LANE_COUNT; i++) begin
                out_data[i] <= IDLE_DATA;
                out_ctl[i]  <= IDLE_CTL;
            end
        end else begin
            for (int i = 0; i < LANE_COUNT; i++) begin
                out_data[i] <= in_data[select[i]];
                out_ctl[i]  <= in_ctl[select[i]];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/xswitch_top.sv */
// Top level of the lane switch, configuration byte stream in, sixteen XGMII lanes through
`timescale 1ns/100ps
`default_nettype none

module xswitch_top import xswitch_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  word_t          cfg_data,
    input  keep_t          cfg_keep,
    input  logic           cfg_valid,
    input  logic           cfg_last,
    output logic           cfg_ready,
    output logic           hdr_error,
    input  lane_data_arr_t rx_data,
    input  lane_ctl_arr_t  rx_ctl,
    output lane_data_arr_t tx_data,
    output lane_ctl_arr_t  tx_ctl
);

    eth_hdr_if      hdr_bus ();
    frame_stream_if payload_bus ();
    sel_arr_t       select;

    eth_hdr_parser u_parser (
        .clk       (clk),
        .rst       (rst),
        .in_data   (cfg_data),
        .in_keep   (cfg_keep),
        .in_valid  (cfg_valid),
        .in_last   (cfg_last),
        .in_ready  (cfg_ready),
        .hdr       (hdr_bus.source),
        .payload   (payload_bus.source),
        .hdr_error (hdr_error)
    );

    xswitch_cfg u_cfg (
        .clk     (clk),
        .rst     (rst),
        .hdr     (hdr_bus.sink),
        .payload (payload_bus.sink),
        .select  (select)
    );

    lane_crosspoint u_xpoint (
        .clk      (clk),
        .rst      (rst),
        .select   (select),
        .in_data  (rx_data),
        .in_ctl   (rx_ctl),
        .out_data (tx_data),
        .out_ctl  (tx_ctl)
    );

endmodule

`default_nettype wire

/* tb/tb_xswitch.sv */
// Directed testbench for the lane switch, sends configuration frames and checks lane routing
`timescale 1ns/100ps
`default_nettype none

module tb_xswitch import xswitch_pkg::*; ();

    localparam int WAIT_LIMIT  = 200;
    localparam int HOLD_CYCLES = 6;

    logic           clk;
    logic           rst;
    word_t          cfg_data;
    keep_t          cfg_keep;
    logic           cfg_valid;
    logic           cfg_last;
    logic           cfg_ready;
    logic           hdr_error;
    lane_data_arr_t rx_data;
    lane_ctl_arr_t  rx_ctl;
    lane_data_arr_t tx_data;
    lane_ctl_arr_t  tx_ctl;

    logic [31:0] lcg_state;
    sel_arr_t    sel_model;
    sel_arr_t    perm;
    sel_arr_t    saved_perm;
    logic [7:0]  frame_q[$];
    logic [7:0]  saved_q[$];
    int          err_count = 0;

    xswitch_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Counts header error pulses
    always @(negedge clk) begin
        if (hdr_error) begin
            err_count++;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        // High half first, the low bits of an LCG repeat quickly
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_lanes(input string name, input lane_data_arr_t exp_data,
                               input lane_data_arr_t act_data, input lane_ctl_arr_t exp_ctl,
                               input lane_ctl_arr_t act_ctl);
        if (act_data !== exp_data || act_ctl !== exp_ctl) begin
            report_failure($sformatf("MISMATCH %s expected %h / %h actual %h / %h",
                name, exp_data, exp_ctl, act_data, act_ctl));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
        end
    endtask

    // Sends frame_q as 64-bit words, byte 0 in the low bits
    task automatic send_frame(input bit gaps);
        word_t data;
        keep_t keep;
        int    n_words;
        int    idx;
        int    t;
        n_words = (frame_q.size() + DATA_BYTES - 1) / DATA_BYTES;
        for (int w = 0; w < n_words; w++) begin
            if (gaps) begin
                cfg_valid <= 1'b0;
                repeat (lcg_next() % 32'd4) @(posedge clk);
            end
            for (int b = 0; b < DATA_BYTES; b++) begin
                idx = w * DATA_BYTES + b;
                data[8*b +: 8] = (idx < frame_q.size()) ? frame_q[idx] : 8'h00;
                keep[b] = (idx < frame_q.size());
            end
            cfg_data  <= data;
            cfg_keep  <= keep;
            cfg_last  <= (w == n_words - 1);
            cfg_valid <= 1'b1;
            t = 0;
            @(negedge clk);
            while (!cfg_ready) begin
                t++;
                if (t > WAIT_LIMIT) begin
                    report_failure("cfg_ready stayed low while a frame word was offered");
                end
                @(negedge clk);
            end
            @(posedge clk);
        end
        cfg_valid <= 1'b0;
        cfg_last  <= 1'b0;
    endtask

    task automatic make_perm();
        sel_t tmp;
        int   j;
        for (int i = 0; i < LANE_COUNT; i++) begin
            perm[i] = sel_t'(i);
        end
        for (int i = LANE_COUNT - 1; i > 0; i--) begin
            j = int'(lcg_next() % 32'(i + 1));
            tmp = perm[i];
            perm[i] = perm[j];
            perm[j] = tmp;
        end
    endtask

    task automatic build_frame(input ethertype_t etype, input int n_payload);
        frame_q.delete();
        // Destination and source MAC
        for (int b = 0; b < 12; b++) begin
            frame_q.push_back(8'(lcg_next()));
        end
        frame_q.push_back(etype[15:8]);
        frame_q.push_back(etype[7:0]);
        for (int b = 0; b < DATA_BYTES * n_payload; b++) begin
            if (b < LANE_COUNT) begin
                // Random upper nibble, only the low nibble is a lane index
                frame_q.push_back({4'(lcg_next()), perm[b]});
            end else begin
                frame_q.push_back(8'(lcg_next()));
            end
        end
    endtask

    // The payload word carrying last never loads selects
    task automatic apply_model(input int n_payload);
        for (int k = 0; k < LANE_COUNT; k++) begin
            if (k / DATA_BYTES < n_payload - 1) begin
                sel_model[k] = perm[k];
            end
        end
    endtask

    task automatic check_routing(input string name);
        lane_data_arr_t exp_data;
        lane_ctl_arr_t  exp_ctl;
        int             t;
        // Distinct lane data, the top byte carries the lane number
        for (int i = 0; i < LANE_COUNT; i++) begin
            rx_data[i] <= {8'(i), 24'(lcg_next()), lcg_next()};
            rx_ctl[i]  <= 8'(lcg_next());
        end
        repeat (HOLD_CYCLES) @(posedge clk);
        for (int i = 0; i < LANE_COUNT; i++) begin
            exp_data[i] = rx_data[sel_model[i]];
            exp_ctl[i]  = rx_ctl[sel_model[i]];
        end
        t = 0;
        @(negedge clk);
        while ((tx_data !== exp_data || tx_ctl !== exp_ctl) && t < WAIT_LIMIT) begin
            t++;
            @(negedge clk);
        end
        check_lanes(name, exp_data, tx_data, exp_ctl, tx_ctl);
        @(posedge clk);
    endtask

    task automatic apply_reset();
        rst <= 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_lanes("reset_idle", {LANE_COUNT{IDLE_DATA}}, tx_data,
                    {LANE_COUNT{IDLE_CTL}}, tx_ctl);
        check_flag("reset_cfg_ready", 1'b1, cfg_ready);
        check_flag("reset_hdr_error", 1'b0, hdr_error);
        @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic test_cfg_frame(input string name, input int n_payload);
        make_perm();
        build_frame(CFG_ETHERTYPE, n_payload);
        send_frame(1'b0);
        apply_model(n_payload);
        check_routing(name);
    endtask

    task automatic test_other_type();
        make_perm();
        build_frame(16'h0800, 3);
        send_frame(1'b0);
        check_routing("other_type_kept");
        // Same frame again, then a configuration frame straight after it
        send_frame(1'b0);
        test_cfg_frame("cfg_after_other", 3);
    endtask

    task automatic test_short_frame();
        int start_count;
        start_count = err_count;
        frame_q.delete();
        for (int b = 0; b < 13; b++) begin
            frame_q.push_back(8'(lcg_next()));
        end
        send_frame(1'b0);
        check_routing("short_kept");
        check_flag("short_hdr_error", 1'b1, err_count != start_count);
        test_cfg_frame("cfg_after_short", 3);
    endtask

    task automatic test_gap_frame();
        test_cfg_frame("gap_reference", 3);
        saved_q = frame_q;
        saved_perm = perm;
        test_cfg_frame("gap_other", 3);
        frame_q = saved_q;
        perm = saved_perm;
        send_frame(1'b1);
        apply_model(3);
        check_routing("gap_frame");
    endtask

    initial begin
        lcg_state = 32'd23;
        cfg_data  <= '0;
        cfg_keep  <= '0;
        cfg_valid <= 1'b0;
        cfg_last  <= 1'b0;
        rx_data   <= '0;
        rx_ctl    <= '0;
        for (int i = 0; i < LANE_COUNT; i++) begin
            sel_model[i] = sel_t'(i);
        end
        apply_reset();
        check_routing("reset_identity");
        test_cfg_frame("cfg_frame", 3);
        test_other_type();
        test_cfg_frame("two_words", 2);
        test_short_frame();
        test_gap_frame();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
hdl/xswitch_pkg.sv
hdl/eth_hdr_if.sv
hdl/frame_stream_if.sv
hdl/eth_hdr_parser.sv
hdl/xswitch_cfg.sv
hdl/lane_crosspoint.sv
hdl/xswitch_top.sv
tb/tb_xswitch.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_xswitch
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)
